/* common/cfg_buf_pkg.sv */
// Configuration write buffer shared types
// Lane count, byte and word types, and the input byte beat
`default_nettype none

package cfg_buf_pkg;

  // Byte lanes per FIFO word, fixed
  localparam int unsigned LANES = 4;

  // One configuration byte from the host
  typedef logic [7:0] cfg_byte_t;

  // One FIFO word
  // Byte 0 sits in the lowest lane
  typedef logic [LANES*8-1:0] cfg_word_t;

  // Per-lane write strobe
  typedef logic [LANES-1:0] lane_mask_t;

  // Next lane to fill inside the open word
  typedef logic [$clog2(LANES)-1:0] lane_idx_t;

  // Input beat, one byte plus its end marker
  // last closes the current word early
  typedef struct packed {
    cfg_byte_t data;
    logic      last;
  } byte_beat_t;

endpackage

`default_nettype wire

/* byte_fifo/lane_regfile.sv */
// One byte lane of the word FIFO storage
// Clocked write, asynchronous read
`timescale 1ns/10ps
`default_nettype none

module lane_regfile #(
  parameter int depth_bits = 2
) (
  input  logic                      fifo_clk,
  input  logic                      wr_en,
  input  logic [depth_bits-1:0]     wr_addr,
  input  cfg_buf_pkg::cfg_byte_t    wr_data,
  input  logic [depth_bits-1:0]     rd_addr,
  output cfg_buf_pkg::cfg_byte_t    rd_data
);
  import cfg_buf_pkg::*;

  localparam int entries = 2 ** depth_bits;

  // Byte storage, one entry per FIFO slot
  cfg_byte_t mem [entries];

  // Write port
  always_ff @(posedge fifo_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, no output register
  // head of FIFO is visible in the same cycle
  assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

/* byte_fifo/byte_fifo.sv */
// Word FIFO with independent byte-lane writes
// Lane strobes fill the slot at the write pointer, commit advances it
`timescale 1ns/10ps
`default_nettype none

module byte_fifo #(
  parameter int depth_bits = 2
) (
  input  logic                    fifo_clk,
  input  logic                    fifo_rst_n,
  input  cfg_buf_pkg::cfg_word_t  wr_data,
  input  cfg_buf_pkg::lane_mask_t wr_lanes,
  input  logic                    wr_commit,
  input  logic                    pop,
  output cfg_buf_pkg::cfg_word_t  head_word,
  output logic                    empty,
  output logic                    full,
  output logic                    almost_full,
  output logic                    almost_empty
);
  import cfg_buf_pkg::*;

  localparam int byte_w = $bits(cfg_byte_t);

  // Occupancy needs one extra bit to reach depth
  typedef logic [depth_bits:0]   count_t;
  typedef logic [depth_bits-1:0] ptr_t;

  count_t count_cs;
  count_t count_ns;
  ptr_t   wr_ptr_cs;
  ptr_t   wr_ptr_ns;
  ptr_t   rd_ptr_cs;
  ptr_t   rd_ptr_ns;

  // Level flags straight from the count
  assign full         = count_cs[depth_bits];
  assign empty        = (count_cs == '0);
  assign almost_full  = (count_cs == count_t'({depth_bits{1'b1}}));
  assign almost_empty = (count_cs == count_t'(1));

  // Occupancy update
  // commit and pop together cancel out
  always_comb begin
    if (wr_commit && pop) begin
      count_ns = count_cs;
    end else if (wr_commit) begin
      count_ns = count_cs + count_t'(1);
    end else if (pop) begin
      count_ns = count_cs - count_t'(1);
    end else begin
      count_ns = count_cs;
    end
  end

  // Pointers wrap naturally at depth
  always_comb begin
    wr_ptr_ns = wr_ptr_cs;
    rd_ptr_ns = rd_ptr_cs;
    if (wr_commit) begin
      wr_ptr_ns = wr_ptr_cs + ptr_t'(1);
    end
    if (pop) begin
      rd_ptr_ns = rd_ptr_cs + ptr_t'(1);
    end
  end

  always_ff @(posedge fifo_clk or negedge fifo_rst_n) begin
    if (!fifo_rst_n) begin
      count_cs  <= '0;
      wr_ptr_cs <= '0;
      rd_ptr_cs <= '0;
    end else begin
      count_cs  <= count_ns;
      wr_ptr_cs <= wr_ptr_ns;
      rd_ptr_cs <= rd_ptr_ns;
    end
  end

  // Storage split per lane
  // Lane writes land in the open slot whether or not it commits this cycle
  for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
    lane_regfile #(
      .depth_bits(depth_bits)
    ) u_lane (
      .fifo_clk (fifo_clk),
      .wr_en    (wr_lanes[lane]),
      .wr_addr  (wr_ptr_cs),
      .wr_data  (wr_data[lane*byte_w +: byte_w]),
      .rd_addr  (rd_ptr_cs),
      .rd_data  (head_word[lane*byte_w +: byte_w])
    );
  end

endmodule

`default_nettype wire

/* src/byte_packer.sv */
// Byte packer for the configuration write buffer
// Steers each accepted byte into its FIFO lane and commits whole words
`timescale 1ns/10ps
`default_nettype none

module byte_packer (
  input  logic                    fifo_clk,
  input  logic                    fifo_rst_n,
  input  cfg_buf_pkg::byte_beat_t in_beat,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  logic                    full,
  output cfg_buf_pkg::cfg_word_t  wr_data,
  output cfg_buf_pkg::lane_mask_t wr_lanes,
  output logic                    wr_commit
);
  import cfg_buf_pkg::*;

  lane_idx_t  lane_idx_cs;
  lane_idx_t  lane_idx_ns;
  logic       accept;
  logic       top_lane;
  lane_mask_t lane_one;
  lane_mask_t lane_rest;

  // At full the open slot is the head word, so hold off the host
  assign in_ready = ~full;
  assign accept   = in_valid & in_ready;

  // Last lane of the word reached
  assign top_lane = (lane_idx_cs == lane_idx_t'(LANES - 1));

  // Strobe for the current lane alone
  assign lane_one  = lane_mask_t'(1) << lane_idx_cs;
  // Current lane plus every lane above it
  assign lane_rest = {LANES{1'b1}} << lane_idx_cs;

  // Byte goes to its lane, zeros elsewhere
  // The zeros become the padding on an early last
  assign wr_data = cfg_word_t'(in_beat.data) << {lane_idx_cs, 3'b000};

  always_comb begin
    if (!accept) begin
      wr_lanes = '0;
    end else if (in_beat.last) begin
      wr_lanes = lane_rest;
    end else begin
      wr_lanes = lane_one;
    end
  end

  // Word closes on lane 3 or on a last marker
  assign wr_commit = accept & (top_lane | in_beat.last);

  // Lane index
  // back to lane 0 after any commit
  always_comb begin
    lane_idx_ns = lane_idx_cs;
    if (wr_commit) begin
      lane_idx_ns = '0;
    end else if (accept) begin
      lane_idx_ns = lane_idx_cs + lane_idx_t'(1);
    end
  end

  always_ff @(posedge fifo_clk or negedge fifo_rst_n) begin
    if (!fifo_rst_n) begin
      lane_idx_cs <= '0;
    end else begin
      lane_idx_cs <= lane_idx_ns;
    end
  end

endmodule

`default_nettype wire

/* src/word_drain.sv */
// Output stage of the configuration write buffer
// One-entry valid/ready register fed from the FIFO head
`timescale 1ns/10ps
`default_nettype none

module word_drain (
  input  logic                   fifo_clk,
  input  logic                   fifo_rst_n,
  input  cfg_buf_pkg::cfg_word_t head_word,
  input  logic                   empty,
  output logic                   pop,
  output cfg_buf_pkg::cfg_word_t out_word,
  output logic                   out_valid,
  input  logic                   out_ready
);
  import cfg_buf_pkg::*;

  logic      load;
  logic      slot_free;
  cfg_word_t out_word_q;

  // Register empty, or emptied by a transfer this cycle
  assign slot_free = ~out_valid | out_ready;

  // Refill from the FIFO head whenever there is room
  assign load = ~empty & slot_free;
  assign pop  = load;

  // Valid flag
  // drops only after a transfer with nothing behind it
  always_ff @(posedge fifo_clk or negedge fifo_rst_n) begin
    if (!fifo_rst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Payload, held stable until taken
  always_ff @(posedge fifo_clk) begin
    if (load) begin
      out_word_q <= head_word;
    end
  end

  assign out_word = out_word_q;

endmodule

`default_nettype wire

/* src/cfg_write_buffer.sv */
// Configuration write buffer top level
// Byte packer into a byte-lane FIFO, drained through an output register
`timescale 1ns/10ps
`default_nettype none

module cfg_write_buffer #(
  parameter int fifo_depth_bits = 2
) (
  input  logic                    fifo_clk,
  input  logic                    fifo_rst_n,
  // Host byte stream
  input  cfg_buf_pkg::byte_beat_t in_beat,
  input  logic                    in_valid,
  output logic                    in_ready,
  // Word stream towards the fabric
  output cfg_buf_pkg::cfg_word_t  out_word,
  output logic                    out_valid,
  input  logic                    out_ready,
  // FIFO level status
  output logic                    almost_full,
  output logic                    almost_empty
);
  import cfg_buf_pkg::*;

  // Packer to FIFO
  cfg_word_t  wr_data;
  lane_mask_t wr_lanes;
  logic       wr_commit;
  logic       full;

  // FIFO to drain
  cfg_word_t  head_word;
  logic       empty;
  logic       pop;

  byte_packer u_packer (
    .fifo_clk   (fifo_clk),
    .fifo_rst_n (fifo_rst_n),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .full       (full),
    .wr_data    (wr_data),
    .wr_lanes   (wr_lanes),
    .wr_commit  (wr_commit)
  );

  byte_fifo #(
    .depth_bits (fifo_depth_bits)
  ) u_fifo (
    .fifo_clk     (fifo_clk),
    .fifo_rst_n   (fifo_rst_n),
    .wr_data      (wr_data),
    .wr_lanes     (wr_lanes),
    .wr_commit    (wr_commit),
    .pop          (pop),
    .head_word    (head_word),
    .empty        (empty),
    .full         (full),
    .almost_full  (almost_full),
    .almost_empty (almost_empty)
  );

  word_drain u_drain (
    .fifo_clk   (fifo_clk),
    .fifo_rst_n (fifo_rst_n),
    .head_word  (head_word),
    .empty      (empty),
    .pop        (pop),
    .out_word   (out_word),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// Testbench clock source
// Free-running clock with an 8 ns period
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter realtime half_period = 4.0
) (
  output logic fifo_clk
);

  // Starts low, first rising edge at half a period
  initial begin
    fifo_clk = 1'b0;
    forever begin
      #(half_period) fifo_clk = ~fifo_clk;
    end
  end

endmodule

`default_nettype wire

/* dv/tb_cfg_write_buffer.sv */
// Testbench for the configuration write buffer
// Random byte streams against a packing model, with back-pressure, flags and latency
`timescale 1ns/10ps
`default_nettype none

module tb_cfg_write_buffer;
  import cfg_buf_pkg::*;

  localparam int depth_bits = 2;
  localparam int depth      = 2 ** depth_bits;
  // Beats driven by all tests together
  // Sets the watchdog length
  localparam int pack_bytes  = 160;
  localparam int mixed_bytes = 80;
  localparam int total_beats = pack_bytes + mixed_bytes + 18 + 24 + 5;

  logic       fifo_clk;
  logic       fifo_rst_n;
  byte_beat_t in_beat;
  logic       in_valid;
  logic       in_ready;
  cfg_word_t  out_word;
  logic       out_valid;
  logic       out_ready;
  logic       almost_full;
  logic       almost_empty;

  // Reference model state
  cfg_word_t exp_q[$];
  cfg_word_t open_word;
  int        open_lane;
  cfg_word_t exp_word;
  cfg_word_t held_word;
  logic      hold_prev;
  string     test_name;

  tb_clk_gen u_clk_gen (
    .fifo_clk (fifo_clk)
  );

  cfg_write_buffer #(
    .fifo_depth_bits (depth_bits)
  ) UUT (
    .fifo_clk     (fifo_clk),
    .fifo_rst_n   (fifo_rst_n),
    .in_beat      (in_beat),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .out_word     (out_word),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .almost_full  (almost_full),
    .almost_empty (almost_empty)
  );

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("MISMATCH test=%s check=%s expected=%08h actual=%08h",
             test_name, what, expected, actual);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_failure(input string what);
    $display("ERROR in test %s: %s", test_name, what);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // Monitor samples mid-cycle where inputs and outputs are stable
  // A handshake seen now completes at the coming rising edge
  always @(negedge fifo_clk) begin
    if (fifo_rst_n) begin
      // Little-endian byte packing with zeros above a last byte
      if (in_valid && in_ready) begin
        open_word[open_lane*8 +: 8] = in_beat.data;
        if (in_beat.last || open_lane == LANES - 1) begin
          exp_q.push_back(open_word);
          open_word = '0;
          open_lane = 0;
        end else begin
          open_lane++;
        end
      end
      // Output word against the oldest expected one
      if (out_valid && out_ready) begin
        assert (exp_q.size() != 0) else report_failure("output word with no bytes behind it");
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          assert (out_word == exp_word) else report_mismatch("out_word", exp_word, out_word);
        end
      end
      // Stalled word must stay put
      if (hold_prev) begin
        assert (out_valid) else report_failure("out_valid dropped before the transfer");
        assert (out_word == held_word) else report_mismatch("held out_word", held_word, out_word);
      end
      hold_prev = out_valid && !out_ready;
      held_word = out_word;
    end
  end

  // Hang guard
  initial begin
    repeat (total_beats * 20 + 200) @(posedge fifo_clk);
    $display("ERROR: watchdog expired, the run hung in test %s", test_name);
    $display("Test FAILED");
    $fatal(1, "watchdog");
  end

  // Random bytes with valid gaps and a random out_ready per cycle
  task automatic stream_bytes(input int n_bytes, input int last_pct, input bit close_word,
                              input int valid_pct, input int ready_pct);
    int sent;
    bit held;
    bit took;
    sent = 0;
    held = 1'b0;
    while (sent < n_bytes) begin
      // Beat stays unchanged until it is taken
      if (!held) begin
        if (($urandom % 100) < valid_pct) begin
          in_beat.data = cfg_byte_t'($urandom);
          in_beat.last = (($urandom % 100) < last_pct) || (close_word && sent == n_bytes - 1);
          in_valid     = 1'b1;
          held         = 1'b1;
        end else begin
          in_valid = 1'b0;
        end
      end
      out_ready = (($urandom % 100) < ready_pct);
      took      = in_valid && in_ready;
      @(posedge fifo_clk);
      #1;
      if (took) begin
        sent++;
        held     = 1'b0;
        in_valid = 1'b0;
      end
    end
    in_valid = 1'b0;
  endtask

  // Back-to-back bytes until max_idle cycles pass without in_ready
  task automatic push_bytes(input int n_bytes, input bit last_end, input int max_idle,
                            output int taken);
    int idle;
    bit took;
    taken        = 0;
    idle         = 0;
    in_beat.data = cfg_byte_t'($urandom);
    in_beat.last = last_end && (n_bytes == 1);
    in_valid     = 1'b1;
    while (taken < n_bytes && idle < max_idle) begin
      took = in_ready;
      @(posedge fifo_clk);
      #1;
      if (took) begin
        taken++;
        idle         = 0;
        in_beat.data = cfg_byte_t'($urandom);
        in_beat.last = last_end && (taken == n_bytes - 1);
      end else begin
        idle++;
      end
    end
    in_valid = 1'b0;
  endtask

  // Empties the buffer with out_ready high
  task automatic wait_drained(input int max_cycles);
    int cycles;
    cycles    = 0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    while ((exp_q.size() != 0 || out_valid) && cycles < max_cycles) begin
      @(posedge fifo_clk);
      #1;
      cycles++;
    end
    assert (exp_q.size() == 0 && !out_valid)
      else report_failure("output stream did not drain in time");
  endtask

  // Level flags from the model occupancy
  // One word sits in the output register
  task automatic check_flags();
    int occ;
    occ = (exp_q.size() > 0) ? exp_q.size() - 1 : 0;
    assert (almost_full == (occ == depth - 1))
      else report_mismatch("almost_full", occ == depth - 1, almost_full);
    assert (almost_empty == (occ == 1))
      else report_mismatch("almost_empty", occ == 1, almost_empty);
  endtask

  initial begin
    int taken;
    int accepted;
    int edges;
    int k;
    void'($urandom(32'h9380_744c));
    test_name    = "reset";
    fifo_rst_n   = 1'b0;
    in_beat      = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    open_word    = '0;
    open_lane    = 0;
    hold_prev    = 1'b0;
    held_word    = '0;
    repeat (2) @(posedge fifo_clk);
    #1;
    fifo_rst_n = 1'b1;

    assert (!out_valid) else report_mismatch("out_valid", 0, out_valid);
    assert (in_ready) else report_mismatch("in_ready", 1, in_ready);
    assert (!almost_full) else report_mismatch("almost_full", 0, almost_full);
    assert (!almost_empty) else report_mismatch("almost_empty", 0, almost_empty);

    // Idle buffer with edges counted from the accepting one
    test_name = "latency";
    for (k = 1; k <= LANES; k += LANES - 1) begin
      out_ready = 1'b1;
      push_bytes(k, 1'b1, 20, taken);
      edges = 1;
      while (!out_valid && edges < 8) begin
        @(posedge fifo_clk);
        #1;
        edges++;
      end
      assert (edges == 2) else report_mismatch("edges to out_valid", 2, edges);
      wait_drained(50);
    end

    test_name = "packing";
    stream_bytes(pack_bytes, 0, 1'b0, 70, 60);
    wait_drained(200);

    // Early last at each lower lane and a whole word from lane 0 after it
    test_name = "partial";
    out_ready = 1'b1;
    for (k = 1; k < LANES; k++) begin
      push_bytes(k, 1'b1, 50, taken);
      assert (taken == k) else report_mismatch("partial bytes taken", k, taken);
      push_bytes(LANES, 1'b0, 50, taken);
    end
    stream_bytes(mixed_bytes, 30, 1'b1, 80, 70);
    wait_drained(200);

    // Stalled output lets the buffer fill one word at a time
    test_name = "back_pressure";
    out_ready = 1'b0;
    accepted  = 0;
    for (k = 0; k <= depth + 1; k++) begin
      push_bytes(LANES, 1'b0, 12, taken);
      accepted += taken;
      repeat (3) @(posedge fifo_clk);
      #1;
      check_flags();
    end
    assert (accepted == (depth + 1) * LANES)
      else report_mismatch("bytes accepted", (depth + 1) * LANES, accepted);
    assert (!in_ready) else report_mismatch("in_ready at full", 0, in_ready);
    wait_drained(100);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
common/cfg_buf_pkg.sv
byte_fifo/lane_regfile.sv
byte_fifo/byte_fifo.sv
src/byte_packer.sv
src/word_drain.sv
src/cfg_write_buffer.sv
dv/tb_clk_gen.sv
dv/tb_cfg_write_buffer.sv

/* Bender.yml */
package:
  name: cfg_write_buffer

sources:
  - common/cfg_buf_pkg.sv
  - byte_fifo/lane_regfile.sv
  - byte_fifo/byte_fifo.sv
  - src/byte_packer.sv
  - src/word_drain.sv
  - src/cfg_write_buffer.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_cfg_write_buffer.sv
